// File: hw/allocationStage.sv
// Allocation stage of the heap pipeline
// Allocation flags, free stack, high-water mark and per-array sizes
// Legality checks and element slot resolution for each command

`timescale 1ns/1ns
`include "heap_defines.svh"

module allocationStage
  import heapPkg::*;
(
  input  logic       clock,
  input  logic       reset,
  input  heapRequest request,
  input  logic       requestValid,
  output slotOp      op                                 // To element stage
);

  logic [`HEAP_ARRAYS-1:0]     allocated;                // Live array flags
  logic [`HEAP_INDEX_BITS:0]   sizes     [`HEAP_ARRAYS]; // Current sizes
  logic [`HEAP_ARRAY_BITS-1:0] freeStack [`HEAP_ARRAYS]; // Freed numbers
  logic [`HEAP_ARRAY_BITS:0]   freeTop;                  // Entries on stack
  logic [`HEAP_ARRAY_BITS:0]   highWater;                // Never-used numbers start here

  logic [`HEAP_INDEX_BITS:0]   curSize;
  logic [`HEAP_INDEX_BITS:0]   newSize;
  logic [`HEAP_ARRAY_BITS-1:0] sizeSlot;                 // Array whose size changes
  logic [`HEAP_ARRAY_BITS-1:0] allocNumber;
  logic [`HEAP_ARRAY_BITS-1:0] stackBelow;               // Top entry of free stack
  heapError                    accessError;
  logic                        outside;                  // Index past size
  logic                        sizeWrite;
  logic                        tableClear;
  logic                        doAlloc;
  logic                        fromStack;
  logic                        doFree;
  slotOp                       next;

  assign curSize    = sizes[request.array];
  assign stackBelow = freeTop[`HEAP_ARRAY_BITS-1:0] - 1'b1;
  assign outside    = {1'b0, request.index} >= curSize;

  always_comb begin
    accessError = noError;
    if ({1'b0, request.array} >= highWater) begin
      accessError = notAllocated;
    end else if (!allocated[request.array]) begin
      accessError = arrayFreed;                          // Also a double free
    end
  end

  // ----------------------------------------------------------
  // Command decode
  // ----------------------------------------------------------
  always_comb begin
    next            = '0;
    next.valid      = requestValid;
    next.action     = request.action;
    next.slot.array = request.array;
    next.slot.index = request.index;
    next.operand    = request.operand;
    newSize         = curSize;
    sizeSlot        = request.array;
    allocNumber     = highWater[`HEAP_ARRAY_BITS-1:0];
    sizeWrite       = 1'b0;
    tableClear      = 1'b0;
    doAlloc         = 1'b0;
    fromStack       = 1'b0;
    doFree          = 1'b0;
    case (request.action)
      Reset: tableClear = 1'b1;
      Write: begin
        next.errorCode = accessError;
        next.access    = accessError == noError;
        sizeWrite      = accessError == noError && outside; // Grow to index plus one
        newSize        = {1'b0, request.index} + 1'b1;
      end
      Read, Add, AddAfter, Subtract, SubAfter, ShiftLeft, ShiftRight,
      NotLogical, Not, Or, Xor, And: begin
        next.errorCode = accessError != noError ? accessError :
                         outside ? outOfBounds : noError;
        next.access    = next.errorCode == noError;
      end
      Size: begin
        next.errorCode = accessError;
        if (accessError == noError) next.tableData[`HEAP_INDEX_BITS:0] = curSize;
      end
      Inc, Push: begin
        next.errorCode = accessError != noError ? accessError :
                         curSize == `HEAP_LENGTH ? arrayFull : noError;
        sizeWrite      = next.errorCode == noError;
        newSize        = curSize + 1'b1;
        next.slot.index = curSize[`HEAP_INDEX_BITS-1:0];   // Push target
        next.access    = request.action == Push && next.errorCode == noError;
      end
      Dec, Pop: begin
        next.errorCode = accessError != noError ? accessError :
                         curSize == '0 ? arrayEmpty : noError;
        sizeWrite      = next.errorCode == noError;
        newSize        = curSize - 1'b1;
        next.slot.index = newSize[`HEAP_INDEX_BITS-1:0];   // Pop source
        next.access    = request.action == Pop && next.errorCode == noError;
      end
      Resize: begin
        next.errorCode = accessError != noError ? accessError :
                         request.operand > `HEAP_LENGTH ? tooLarge : noError;
        sizeWrite      = next.errorCode == noError;
        newSize        = request.operand[`HEAP_INDEX_BITS:0];
      end
      Alloc: begin
        if (freeTop != '0) begin
          allocNumber = freeStack[stackBelow];             // Most recently freed
          fromStack   = 1'b1;
        end else if (highWater == `HEAP_ARRAYS) begin
          next.errorCode = outOfMemory;
        end
        doAlloc         = next.errorCode == noError;
        sizeWrite       = doAlloc;
        sizeSlot        = allocNumber;
        newSize         = '0;                              // Starts empty
        if (doAlloc) next.tableData[`HEAP_ARRAY_BITS-1:0] = allocNumber;
      end
      Free: begin
        next.errorCode = accessError;
        doFree         = accessError == noError;
      end
      default: ;                                           // Unknown code, no effect
    endcase
  end

  // ----------------------------------------------------------
  // Table update and op register
  // ----------------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset || (requestValid && tableClear)) begin
      allocated <= '0;
      freeTop   <= '0;
      highWater <= '0;
      for (int i = 0; i < `HEAP_ARRAYS; i++) sizes[i] <= '0;
    end else if (requestValid) begin
      if (sizeWrite) sizes[sizeSlot] <= newSize;
      if (doAlloc) begin
        allocated[allocNumber] <= 1'b1;
        if (fromStack) freeTop <= freeTop - 1'b1;
        else           highWater <= highWater + 1'b1;
      end
      if (doFree) begin
        allocated[request.array] <= 1'b0;
        freeTop                  <= freeTop + 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (requestValid && doFree) freeStack[freeTop[`HEAP_ARRAY_BITS-1:0]] <= request.array;
  end

  always_ff @(posedge clock) begin
    if (reset) op <= '0;
    else       op <= next;
  end

  stackBound: assert property (@(posedge clock) disable iff (reset)
    freeTop <= `HEAP_ARRAYS);

  // A storage access stays inside the updated size of an array that was handed out
  slotBound: assert property (@(posedge clock) disable iff (reset)
    op.valid && op.access && op.errorCode == noError |->
      {1'b0, op.slot.index} <= sizes[op.slot.array] &&
      {1'b0, op.slot.array} < highWater);

endmodule

// File: hw/busFront.sv
// Wishbone classic slave of the heap
// One command per bus cycle, acknowledged once the pipeline answers

`timescale 1ns/1ns
`include "heap_defines.svh"

module busFront
  import heapPkg::*;
(
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      wbCyc,
  input  logic                      wbStb,
  input  logic [`HEAP_BUS_BITS-1:0] wbDatIn,      // Command word
  input  heapResponse               response,     // From element stage
  input  logic                      done,         // Response valid
  output heapRequest                request,
  output logic                      requestValid, // One-cycle pulse
  output logic [`HEAP_BUS_BITS-1:0] wbDatOut,
  output logic                      wbAck
);

  logic busy;                                     // Command in flight
  logic accept;                                   // Idle and strobed

  assign accept = wbCyc && wbStb && !busy;

  // ----------------------------------------------------------
  // Handshake control
  // ----------------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      busy         <= 1'b0;
      requestValid <= 1'b0;
      wbAck        <= 1'b0;
    end else begin
      requestValid <= accept;                     // Into allocation stage
      wbAck        <= done;                       // Single-cycle acknowledge
      if (accept) begin
        busy <= 1'b1;
      end else if (wbAck) begin
        // Master samples ack at this edge and drops strobe with it,
        // so the stale strobe is not taken as a new command
        busy <= 1'b0;
      end
    end
  end

  // ----------------------------------------------------------
  // Command and response words
  // ----------------------------------------------------------
  always_ff @(posedge clock) begin
    if (accept) begin
      request <= heapRequest'(wbDatIn[$bits(heapRequest)-1:0]);
    end
    if (done) begin
      wbDatOut <= {{(`HEAP_BUS_BITS - $bits(heapResponse)){1'b0}}, response}; // Upper bits zero
    end
  end

  // Acknowledge is a pulse per command
  ackPulse: assert property (@(posedge clock) disable iff (reset)
    wbAck |=> !wbAck);

endmodule

// File: hw/elementStage.sv
// Element stage of the heap pipeline
// Element storage with a read-modify-write arithmetic unit

`timescale 1ns/1ns
`include "heap_defines.svh"

module elementStage
  import heapPkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  slotOp       op,                               // From allocation stage
  output heapResponse response,
  output logic        done                              // One cycle per op
);

  logic [`HEAP_DATA_BITS-1:0]                   storage [`HEAP_SLOTS];
  logic [`HEAP_ARRAY_BITS+`HEAP_INDEX_BITS-1:0] slotAddress;
  logic [`HEAP_DATA_BITS-1:0]                   element;  // Current slot value
  logic [`HEAP_DATA_BITS-1:0]                   newValue; // Value written back
  logic [`HEAP_DATA_BITS-1:0]                   data;     // Response data
  logic                                         writeBack;
  logic                                         clearAll;

  assign slotAddress = op.slot;                          // Array-major layout
  assign element     = storage[slotAddress];
  assign clearAll    = op.valid && op.action == Reset;

  // ----------------------------------------------------------
  // Arithmetic unit
  // ----------------------------------------------------------
  always_comb begin
    newValue  = element;
    writeBack = 1'b1;
    data      = '0;
    case (op.action)
      Write: begin
        newValue = op.operand;
        data     = op.operand;
      end
      Push:       newValue = op.operand;                 // Answers zero
      Add:        newValue = element + op.operand;
      AddAfter:   newValue = element + op.operand;
      Subtract:   newValue = element - op.operand;
      SubAfter:   newValue = element - op.operand;
      ShiftLeft:  newValue = element << op.operand;     // Zero from 16 up
      ShiftRight: newValue = element >> op.operand;
      NotLogical: begin
        newValue    = '0;
        newValue[0] = element == '0;
      end
      Not:        newValue = ~element;
      Or:         newValue = element | op.operand;
      Xor:        newValue = element ^ op.operand;
      And:        newValue = element & op.operand;
      default:    writeBack = 1'b0;                      // Read, Pop, table-only ops
    endcase
    case (op.action)
      Read, Pop, AddAfter, SubAfter: data = element;     // Old value
      Add, Subtract, ShiftLeft, ShiftRight, NotLogical, Not, Or, Xor, And:
        data = newValue;
      Size, Alloc: data = op.tableData;
      default: ;
    endcase
    if (!op.access || op.errorCode != noError) writeBack = 1'b0;
    if (op.errorCode != noError) data = '0;
  end

  // ----------------------------------------------------------
  // Storage and response registers
  // ----------------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset || clearAll) begin
      for (int i = 0; i < `HEAP_SLOTS; i++) storage[i] <= '0;
    end else if (op.valid && writeBack) begin
      storage[slotAddress] <= newValue;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) done <= 1'b0;
    else       done <= op.valid;
  end

  always_ff @(posedge clock) begin
    response.errorCode <= op.errorCode;
    response.data      <= data;
  end

endmodule

// File: hw/heapMemory.sv
// Top level of the array heap
// Bus front, allocation stage and element stage in a three-stage loop

`timescale 1ns/1ns
`include "heap_defines.svh"

module heapMemory
  import heapPkg::*;
(
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      wbCyc,
  input  logic                      wbStb,
  input  logic [`HEAP_BUS_BITS-1:0] wbDatIn,
  output logic [`HEAP_BUS_BITS-1:0] wbDatOut,
  output logic                      wbAck
);

  heapRequest  request;                                  // Front to allocation
  logic        requestValid;
  slotOp       op;                                       // Allocation to element
  heapResponse response;                                 // Element back to front
  logic        done;

  busFront front (
    .clock        (clock),
    .reset        (reset),
    .wbCyc        (wbCyc),
    .wbStb        (wbStb),
    .wbDatIn      (wbDatIn),
    .response     (response),
    .done         (done),
    .request      (request),
    .requestValid (requestValid),
    .wbDatOut     (wbDatOut),
    .wbAck        (wbAck)
  );

  allocationStage allocation (
    .clock        (clock),
    .reset        (reset),
    .request      (request),
    .requestValid (requestValid),
    .op           (op)
  );

  elementStage elements (
    .clock        (clock),
    .reset        (reset),
    .op           (op),
    .response     (response),
    .done         (done)
  );

endmodule

// File: hw/heapPkg.sv
// Command, error, request, pipeline op and response types of the heap

`include "heap_defines.svh"

package heapPkg;

  typedef enum logic [4:0] {
    Reset      = 5'd1,                       // Clear the whole heap
    Write      = 5'd2,
    Read       = 5'd3,
    Size       = 5'd4,
    Inc        = 5'd5,
    Dec        = 5'd6,
    Push       = 5'd14,
    Pop        = 5'd15,
    Resize     = 5'd17,
    Alloc      = 5'd18,
    Free       = 5'd19,
    Add        = 5'd20,                      // Returns new value
    AddAfter   = 5'd21,                      // Returns old value
    Subtract   = 5'd22,
    SubAfter   = 5'd23,
    ShiftLeft  = 5'd24,
    ShiftRight = 5'd25,
    NotLogical = 5'd26,
    Not        = 5'd27,
    Or         = 5'd28,
    Xor        = 5'd29,
    And        = 5'd30
  } heapAction;

  typedef enum logic [3:0] {
    noError      = 4'd0,
    notAllocated = 4'd1,                     // At or above high-water mark
    arrayFreed   = 4'd2,
    outOfBounds  = 4'd3,
    arrayFull    = 4'd4,
    arrayEmpty   = 4'd5,
    outOfMemory  = 4'd6,
    tooLarge     = 4'd7
  } heapError;

  // Low bits of the bus input word
  typedef struct packed {
    heapAction                   action;
    logic [`HEAP_ARRAY_BITS-1:0] array;
    logic [`HEAP_INDEX_BITS-1:0] index;
    logic [`HEAP_DATA_BITS-1:0]  operand;
  } heapRequest;

  typedef struct packed {
    logic [`HEAP_ARRAY_BITS-1:0] array;
    logic [`HEAP_INDEX_BITS-1:0] index;      // Resolved element index
  } heapSlot;

  typedef struct packed {
    logic                        valid;
    heapAction                   action;
    heapSlot                     slot;
    logic [`HEAP_DATA_BITS-1:0]  operand;
    heapError                    errorCode;
    logic [`HEAP_DATA_BITS-1:0]  tableData;  // Size or allocated number
    logic                        access;     // Storage is touched
  } slotOp;

  // Low bits of the bus output word
  typedef struct packed {
    heapError                    errorCode;
    logic [`HEAP_DATA_BITS-1:0]  data;
  } heapResponse;

endpackage

// File: include/heap_defines.svh
// Width and size macros of the array heap
// Array numbers, element indices, element width and the bus word

`ifndef HEAP_DEFINES_SVH
`define HEAP_DEFINES_SVH

// ----------------------------------------------------------
// Address fields
// ----------------------------------------------------------
`define HEAP_ARRAY_BITS 3                    // Bits in an array number
`define HEAP_INDEX_BITS 3                    // Bits in an element index

// ----------------------------------------------------------
// Sizes
// ----------------------------------------------------------
`define HEAP_DATA_BITS  16                   // Element width
`define HEAP_ARRAYS     8                    // Arrays in the heap
`define HEAP_LENGTH     8                    // Capacity of one array

// Every element slot of every array
`define HEAP_SLOTS      (`HEAP_ARRAYS * `HEAP_LENGTH)

// ----------------------------------------------------------
// Bus
// ----------------------------------------------------------
`define HEAP_BUS_BITS   32                   // Wishbone data width

`endif

// File: run.sh
#!/usr/bin/env bash
# Build the heap testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module heapMemoryTb \
  -f sources.f -o heapSim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/heapSim > sim.log 2>&1 || echo "simulator returned an error" >> sim.log
cat sim.log
grep -q "TEST FAIL" sim.log && exit 1
grep -q "TEST PASS" sim.log || exit 1
exit 0

// File: sim/heapMemoryTb.sv
// Testbench of the array heap behind its Wishbone classic port
// Reference model, directed checks and seeded random commands

`timescale 1ns/1ns
`include "heap_defines.svh"

module heapMemoryTb
  import heapPkg::*;
;

  logic                      clock;
  logic                      reset;
  logic                      wbCyc;
  logic                      wbStb;
  logic [`HEAP_BUS_BITS-1:0] wbDatIn;
  logic [`HEAP_BUS_BITS-1:0] wbDatOut;
  logic                      wbAck;

  int          valueErrors;
  int          timeoutErrors;
  bit          stalled;                              // Bus stopped answering
  logic [3:0]  lastError;
  logic [15:0] lastData;

  // Reference model state
  logic [15:0] modelElems [64];
  int          modelSizes [8];
  bit          modelAllocated [8];
  int          modelStack [8];
  int          modelTop;
  int          modelHigh;

  logic [4:0] commandCodes [22] = '{Write, Read, Size, Inc, Dec, Push, Pop, Resize,
    Alloc, Alloc, Free, Add, AddAfter, Subtract, SubAfter, ShiftLeft, ShiftRight,
    NotLogical, Not, Or, Xor, And};                  // Alloc twice to keep arrays live
  logic [4:0] unknownCodes [4] = '{5'd0, 5'd7, 5'd16, 5'd31};

  heapMemory uut (
    .clock    (clock),
    .reset    (reset),
    .wbCyc    (wbCyc),
    .wbStb    (wbStb),
    .wbDatIn  (wbDatIn),
    .wbDatOut (wbDatOut),
    .wbAck    (wbAck)
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;                       // 8 ns period
  end

  // ----------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------
  function automatic void clearModel();
    for (int i = 0; i < 64; i++) modelElems[i] = '0;
    for (int i = 0; i < 8; i++) begin
      modelSizes[i]     = 0;
      modelAllocated[i] = 1'b0;
    end
    modelTop  = 0;
    modelHigh = 0;
  endfunction

  function automatic void predict(input logic [4:0] action, input int array, input int index,
                                  input logic [15:0] operand,
                                  output logic [3:0] err, output logic [15:0] data);
    logic [3:0]  acc;
    logic [15:0] old;
    int          slot;
    int          n;
    acc  = noError;
    err  = noError;
    data = '0;
    n    = 0;
    if (array >= modelHigh) acc = notAllocated;     // Never handed out
    else if (!modelAllocated[array]) acc = arrayFreed;
    slot = array * 8 + index;
    old  = modelElems[slot];
    case (action)
      Reset: clearModel();
      Write: begin
        err = acc;
        if (err == noError) begin
          if (index >= modelSizes[array]) modelSizes[array] = index + 1;
          modelElems[slot] = operand;
          data = operand;
        end
      end
      Size: begin
        err = acc;
        if (err == noError) data = modelSizes[array];
      end
      Inc, Push: begin
        err = acc != noError ? acc : modelSizes[array] == 8 ? arrayFull : noError;
        if (err == noError) begin
          if (action == Push) modelElems[array * 8 + modelSizes[array]] = operand;
          modelSizes[array]++;
        end
      end
      Dec, Pop: begin
        err = acc != noError ? acc : modelSizes[array] == 0 ? arrayEmpty : noError;
        if (err == noError) begin
          modelSizes[array]--;
          if (action == Pop) data = modelElems[array * 8 + modelSizes[array]];
        end
      end
      Resize: begin
        err = acc != noError ? acc : operand > 8 ? tooLarge : noError;
        if (err == noError) modelSizes[array] = operand;
      end
      Alloc: begin
        if (modelTop > 0) begin                      // Last freed comes back first
          modelTop--;
          n = modelStack[modelTop];
        end else if (modelHigh == 8) begin
          err = outOfMemory;
        end else begin
          n = modelHigh;
          modelHigh++;
        end
        if (err == noError) begin
          modelAllocated[n] = 1'b1;
          modelSizes[n]     = 0;
          data              = n;
        end
      end
      Free: begin
        err = acc;
        if (err == noError) begin
          modelStack[modelTop] = array;
          modelTop++;
          modelAllocated[array] = 1'b0;
        end
      end
      Read, Add, AddAfter, Subtract, SubAfter, ShiftLeft, ShiftRight,
      NotLogical, Not, Or, Xor, And: begin
        err = acc != noError ? acc : index >= modelSizes[array] ? outOfBounds : noError;
        if (err == noError) begin
          case (action)
            Add, AddAfter:      modelElems[slot] = old + operand;
            Subtract, SubAfter: modelElems[slot] = old - operand;
            ShiftLeft:  modelElems[slot] = operand >= 16 ? 16'h0 : old << operand;
            ShiftRight: modelElems[slot] = operand >= 16 ? 16'h0 : old >> operand;
            NotLogical: modelElems[slot] = old == 16'h0 ? 16'h1 : 16'h0;
            Not:        modelElems[slot] = ~old;
            Or:         modelElems[slot] = old | operand;
            Xor:        modelElems[slot] = old ^ operand;
            And:        modelElems[slot] = old & operand;
            default: ;                               // Read leaves the element
          endcase
          if (action == Read || action == AddAfter || action == SubAfter) data = old;
          else data = modelElems[slot];
        end
      end
      default: ;                                     // Unknown code
    endcase
  endfunction

  // ----------------------------------------------------------
  // Bus master and checks
  // ----------------------------------------------------------
  task automatic checkValue(input string name, input logic [31:0] got,
                            input logic [31:0] want);
    if (got !== want) begin
      $display("ERR %s got %h expected %h", name, got, want);
      valueErrors++;
    end
  endtask

  task automatic runCommand(input logic [4:0] action, input int array, input int index,
                            input logic [15:0] operand);
    logic [3:0]  wantErr;
    logic [15:0] wantData;
    logic [31:0] word;
    logic        acked;
    int          waited;
    if (stalled) return;
    predict(action, array, index, operand, wantErr, wantData);
    @(posedge clock);
    wbCyc   <= 1'b1;
    wbStb   <= 1'b1;
    wbDatIn <= {5'b0, action, array[2:0], index[2:0], operand};
    waited = 0;
    @(negedge clock);
    while (!wbAck && waited < 20) begin              // Ack sampled mid-cycle
      @(negedge clock);
      waited++;
    end
    acked = wbAck;
    word  = wbDatOut;
    @(posedge clock);
    wbCyc <= 1'b0;
    wbStb <= 1'b0;
    if (!acked) begin
      $display("Timeout: no acknowledge within 20 cycles for action code %0d", action);
      timeoutErrors++;
      stalled = 1'b1;
    end else begin
      checkValue("wbAck latency", waited, 32'd4);    // Fourth cycle after acceptance
      checkValue("wbDatOut[31:20]", {20'h0, word[31:20]}, 32'h0);
      checkValue("errorCode", {28'h0, word[19:16]}, {28'h0, wantErr});
      checkValue("data", {16'h0, word[15:0]}, {16'h0, wantData});
      lastError = word[19:16];
      lastData  = word[15:0];
    end
  endtask

  task automatic expectResult(input logic [3:0] wantErr, input logic [15:0] wantData);
    if (!stalled) begin
      checkValue("errorCode", {28'h0, lastError}, {28'h0, wantErr});
      checkValue("data", {16'h0, lastData}, {16'h0, wantData});
    end
  endtask

  // One arithmetic step on element 0 of array 1, then a read back
  task automatic checkArithmetic(input logic [4:0] action, input logic [15:0] operand,
                                 input logic [15:0] wantData, input logic [15:0] wantStored);
    runCommand(action, 1, 0, operand);
    expectResult(noError, wantData);
    runCommand(Read, 1, 0, 16'h0);
    expectResult(noError, wantStored);
  endtask

  // ----------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------
  initial begin
    logic [4:0]  action;
    logic [15:0] operand;
    int          pick;
    void'($urandom(32'h473a));
    reset         = 1'b1;
    wbCyc         = 1'b0;
    wbStb         = 1'b0;
    wbDatIn       = '0;
    valueErrors   = 0;
    timeoutErrors = 0;
    stalled       = 1'b0;
    clearModel();
    repeat (10) @(posedge clock);
    reset <= 1'b0;

    // Allocation order and reuse
    for (int i = 0; i < 9; i++) begin
      runCommand(Alloc, 0, 0, 16'h0);
      if (i < 8) expectResult(noError, i);
      else expectResult(outOfMemory, 16'h0);
    end
    runCommand(Free, 5, 0, 16'h0);
    runCommand(Free, 2, 0, 16'h0);
    runCommand(Alloc, 0, 0, 16'h0);
    expectResult(noError, 16'd2);
    runCommand(Alloc, 0, 0, 16'h0);
    expectResult(noError, 16'd5);

    // Write grows the size
    runCommand(Write, 1, 3, 16'hbeef);
    runCommand(Size, 1, 0, 16'h0);
    expectResult(noError, 16'd4);
    runCommand(Read, 1, 5, 16'h0);
    expectResult(outOfBounds, 16'h0);
    runCommand(Read, 1, 3, 16'h0);
    expectResult(noError, 16'hbeef);

    // Access rules on a cleared heap
    runCommand(Reset, 0, 0, 16'h0);
    runCommand(Alloc, 0, 0, 16'h0);
    runCommand(Read, 4, 0, 16'h0);
    expectResult(notAllocated, 16'h0);
    runCommand(Free, 0, 0, 16'h0);
    runCommand(Write, 0, 0, 16'h1);
    expectResult(arrayFreed, 16'h0);
    runCommand(Free, 0, 0, 16'h0);                   // Double free
    expectResult(arrayFreed, 16'h0);
    runCommand(Alloc, 0, 0, 16'h0);
    expectResult(noError, 16'd0);
    runCommand(Alloc, 0, 0, 16'h0);                  // Stack held one entry only
    expectResult(noError, 16'd1);
    runCommand(Size, 0, 0, 16'h0);
    expectResult(noError, 16'd0);

    // Size limits on array 1
    for (int i = 0; i < 9; i++) begin
      runCommand(Push, 1, 0, 16'h100 + i);
      expectResult(i < 8 ? noError : arrayFull, 16'h0);
    end
    for (int i = 0; i < 9; i++) begin
      runCommand(Pop, 1, 0, 16'h0);
      if (i < 8) expectResult(noError, 16'h107 - i);
      else expectResult(arrayEmpty, 16'h0);
    end
    runCommand(Resize, 1, 0, 16'd8);
    runCommand(Inc, 1, 0, 16'h0);
    expectResult(arrayFull, 16'h0);
    runCommand(Resize, 1, 0, 16'd0);
    runCommand(Dec, 1, 0, 16'h0);
    expectResult(arrayEmpty, 16'h0);
    runCommand(Resize, 1, 0, 16'd9);
    expectResult(tooLarge, 16'h0);

    // Arithmetic chain starting at 1234
    runCommand(Resize, 1, 0, 16'd1);
    runCommand(Write, 1, 0, 16'h1234);
    checkArithmetic(Add, 16'h0010, 16'h1244, 16'h1244);
    checkArithmetic(AddAfter, 16'h0001, 16'h1244, 16'h1245);
    checkArithmetic(Subtract, 16'h0245, 16'h1000, 16'h1000);
    checkArithmetic(SubAfter, 16'h1001, 16'h1000, 16'hffff);
    checkArithmetic(ShiftRight, 16'd4, 16'h0fff, 16'h0fff);
    checkArithmetic(ShiftLeft, 16'd8, 16'hff00, 16'hff00);
    checkArithmetic(Or, 16'h00f0, 16'hfff0, 16'hfff0);
    checkArithmetic(Xor, 16'h0ff0, 16'hf000, 16'hf000);
    checkArithmetic(And, 16'h3000, 16'h3000, 16'h3000);
    checkArithmetic(Not, 16'h0, 16'hcfff, 16'hcfff);
    checkArithmetic(NotLogical, 16'h0, 16'h0, 16'h0);
    checkArithmetic(NotLogical, 16'h0, 16'h1, 16'h1);
    checkArithmetic(ShiftLeft, 16'd16, 16'h0, 16'h0);

    // Random commands against the model
    for (int n = 0; n < 2000; n++) begin
      pick = $urandom % 100;
      if (pick < 2) action = Reset;
      else if (pick < 5) action = unknownCodes[$urandom % 4];
      else action = commandCodes[$urandom % 22];
      if ($urandom % 2) operand = $urandom % 12;     // Reaches resize and shift limits
      else operand = $urandom;
      runCommand(action, $urandom % 8, $urandom % 8, operand);
    end

    $display("Errors: %0d value, %0d timeout", valueErrors, timeoutErrors);
    if (valueErrors == 0 && timeoutErrors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: sources.f
+incdir+include
hw/heapPkg.sv
hw/busFront.sv
hw/allocationStage.sv
hw/elementStage.sv
hw/heapMemory.sv
sim/heapMemoryTb.sv
